//--- build.f
+incdir+common
common/cpu_isa_pkg.sv
execute/alu.sv
execute/reg_file.sv
sequencer/opcode_decoder.sv
sequencer/cpu_sequencer.sv
src/cpu_top.sv
bench/tb_memory.sv
bench/tb_cpu_top.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the core testbench with Verilator
# Pass or fail comes from the pass message in the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --top-module tb_cpu_top -f build.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_cpu_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL TESTS PASSED" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- bench/tb_cpu_top.sv
/*
  Testbench for the reduced 6502 core
  Builds one program from random operands before reset, tracks A, X, Y,
  C and memory in a reference model, then steps through every
  instruction checking fetch address, cycle count and bus writes
*/
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_cpu_top;

  localparam int SYNC_LIMIT  = 16;
  localparam int HALT_WINDOW = 20;

  logic                   clk;
  logic                   resetn;
  logic [`CPU_DATA_W-1:0] rd_data;
  logic [`CPU_ADDR_W-1:0] address;
  logic [`CPU_DATA_W-1:0] wr_data;
  logic                   wr_enable;
  logic                   sync;
  logic                   halted;

  // Reference model state
  logic [7:0]  m_a;
  logic [7:0]  m_x;
  logic [7:0]  m_y;
  logic        m_c;
  logic [7:0]  ref_mem [0:65535];
  logic [15:0] build_pc;
  logic [15:0] data_ptr = 16'h2000;
  logic [15:0] store_ptr = 16'h3000;
  int          cur_test;
  int          seed = 32'haea6_4d47;

  // One entry per instruction in program order
  logic [15:0] exp_pc [$];
  int          exp_len [$];
  int          exp_wr_cnt [$];
  logic [15:0] exp_wr_addr [$];
  logic [7:0]  exp_wr_data [$];
  int          exp_test [$];

  // Writes seen on the bus since the last fetch
  logic [15:0] wr_addr_q [$];
  logic [7:0]  wr_data_q [$];

  int   cycle = 0;
  int   sync_cycle = 0;
  int   release_cycle = 0;
  int   errors = 0;
  int   tests_ok = 0;
  int   tests_bad = 0;
  int   test_err_base = 0;
  logic timed_out = 1'b0;

  cpu_top dut (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable),
    .sync      (sync),
    .halted    (halted)
  );

  tb_memory mem (
    .clk       (clk),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable),
    .rd_data   (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Cycle count and write capture, sampled like a flop
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (resetn && wr_enable) begin
      wr_addr_q.push_back(address);
      wr_data_q.push_back(wr_data);
    end
  end

  // ----------------------------------------
  // Bus rules that hold on every cycle
  halt_quiet: assert property (@(posedge clk) disable iff (!resetn)
      halted |-> (!sync && !wr_enable))
    else begin
      errors = errors + 1;
      $display("mismatch at %0t ns: fetch or write while halted", $time);
    end

  halt_hold: assert property (@(posedge clk) disable iff (!resetn) halted |=> halted)
    else begin
      errors = errors + 1;
      $display("mismatch at %0t ns: halted dropped without reset", $time);
    end

  fetch_no_write: assert property (@(posedge clk) disable iff (!resetn)
      sync |-> !wr_enable)
    else begin
      errors = errors + 1;
      $display("mismatch at %0t ns: write during an opcode fetch", $time);
    end

  function automatic logic [7:0] rand_byte();
    int r;
    r = $random(seed);
    return r[7:0];
  endfunction

  function automatic string test_title(input int t);
    case (t)
      1:       return "reset vector";
      2:       return "loads and stores";
      3:       return "accumulator operations";
      4:       return "read-modify-write";
      5:       return "control flow";
      default: return "illegal opcode";
    endcase
  endfunction

  task automatic check(input logic ok, input string msg);
    assert (ok) else begin
      errors = errors + 1;
      $display("mismatch at %0t ns: %s", $time, msg);
    end
  endtask

  // ----------------------------------------
  // Program building and the reference model
  task automatic data_byte(input logic [15:0] a, input logic [7:0] v);
    mem.load_byte(a, v);
    ref_mem[a] = v;
  endtask

  task automatic record_step(input int len, input int nwr, input logic [15:0] wa,
                             input logic [7:0] wd);
    exp_pc.push_back(build_pc);
    exp_len.push_back(len);
    exp_wr_cnt.push_back(nwr);
    exp_wr_addr.push_back(wa);
    exp_wr_data.push_back(wd);
    exp_test.push_back(cur_test);
  endtask

  task automatic implied_op(input logic [7:0] op);
    mem.load_byte(build_pc, op);
    if (op == `OP_CLC_IMP) begin
      m_c = 1'b0;
    end else if (op == `OP_SEC_IMP) begin
      m_c = 1'b1;
    end
    record_step(2, 0, 16'h0000, 8'h00);
    build_pc = build_pc + 16'd1;
  endtask

  task automatic absolute_op(input logic [7:0] op, input logic [15:0] ea);
    logic [7:0] m;
    logic [8:0] sum;
    logic [7:0] wd;
    int         len;
    int         nwr;
    m   = ref_mem[ea];
    len = 4;
    nwr = 0;
    wd  = 8'h00;
    mem.load_byte(build_pc, op);
    mem.load_byte(build_pc + 16'd1, ea[7:0]);
    mem.load_byte(build_pc + 16'd2, ea[15:8]);
    case (op)
      `OP_LDA_ABS: m_a = m;
      `OP_LDX_ABS: m_x = m;
      `OP_LDY_ABS: m_y = m;
      `OP_STA_ABS: begin
        nwr = 1;
        wd  = m_a;
      end
      `OP_STX_ABS: begin
        nwr = 1;
        wd  = m_x;
      end
      `OP_STY_ABS: begin
        nwr = 1;
        wd  = m_y;
      end
      `OP_ORA_ABS: m_a = m_a | m;
      `OP_AND_ABS: m_a = m_a & m;
      `OP_EOR_ABS: m_a = m_a ^ m;
      `OP_ADC_ABS: begin
        sum = {1'b0, m_a} + {1'b0, m} + {8'h00, m_c};
        m_a = sum[7:0];
        m_c = sum[8];
      end
      // C set when A >= M, A kept
      `OP_CMP_ABS: m_c = (m_a >= m);
      // RMW keeps C, writes M +/- 1 back
      `OP_INC_ABS: begin
        len = 6;
        nwr = 1;
        wd  = m + 8'd1;
      end
      `OP_DEC_ABS: begin
        len = 6;
        nwr = 1;
        wd  = m - 8'd1;
      end
      default: begin
      end
    endcase
    if (nwr == 1) begin
      ref_mem[ea] = wd;
    end
    record_step(len, nwr, ea, wd);
    build_pc = build_pc + 16'd3;
  endtask

  // Operand placed at a fresh data address
  task automatic operand_op(input logic [7:0] op, input logic [7:0] v);
    data_byte(data_ptr, v);
    absolute_op(op, data_ptr);
    data_ptr = data_ptr + 16'd1;
  endtask

  // Stores spread over distinct addresses in both bytes
  task automatic fresh_store(input logic [7:0] op);
    absolute_op(op, store_ptr);
    store_ptr = store_ptr + 16'h0105;
  endtask

  task automatic jump_to(input logic [15:0] target);
    mem.load_byte(build_pc, `OP_JMP_ABS);
    mem.load_byte(build_pc + 16'd1, target[7:0]);
    mem.load_byte(build_pc + 16'd2, target[15:8]);
    record_step(3, 0, 16'h0000, 8'h00);
    build_pc = target;
  endtask

  // Length zero marks the halting entry
  task automatic illegal_op(input logic [7:0] op);
    mem.load_byte(build_pc, op);
    record_step(0, 0, 16'h0000, 8'h00);
    build_pc = build_pc + 16'd1;
  endtask

  task automatic build_program();
    logic [15:0] start;
    logic [7:0]  v;
    int          k;
    int          j;
    m_a = 8'h00;
    m_x = 8'h00;
    m_y = 8'h00;
    m_c = 1'b0;
    start = 16'h0400 | {8'h00, rand_byte() & 8'hF0};
    data_byte(`CPU_RESET_VEC_LO, start[7:0]);
    data_byte(`CPU_RESET_VEC_HI, start[15:8]);
    build_pc = start;
    cur_test = 2;
    operand_op(`OP_LDA_ABS, rand_byte());
    operand_op(`OP_LDX_ABS, rand_byte());
    operand_op(`OP_LDY_ABS, rand_byte());
    fresh_store(`OP_STA_ABS);
    fresh_store(`OP_STX_ABS);
    fresh_store(`OP_STY_ABS);
    // Logic ops and ADC, first with C clear then with C set
    cur_test = 3;
    for (k = 0; k < 2; k++) begin
      for (j = 0; j < 4; j++) begin
        if (j == 3) begin
          implied_op((k == 0) ? `OP_CLC_IMP : `OP_SEC_IMP);
        end
        operand_op(`OP_LDA_ABS, rand_byte());
        operand_op((j == 0) ? `OP_ORA_ABS : (j == 1) ? `OP_AND_ABS :
                   (j == 2) ? `OP_EOR_ABS : `OP_ADC_ABS, rand_byte());
        fresh_store(`OP_STA_ABS);
      end
    end
    // CMP with M below, equal to and above A, carry shown by ADC #0
    for (k = 0; k < 3; k++) begin
      v = rand_byte();
      operand_op(`OP_LDA_ABS, v);
      operand_op(`OP_CMP_ABS, v + 8'(k) - 8'd1);
      operand_op(`OP_ADC_ABS, 8'h00);
      fresh_store(`OP_STA_ABS);
    end
    // INC and DEC across the wrap points, then expose C
    cur_test = 4;
    for (k = 0; k < 4; k++) begin
      v = (k == 0) ? 8'hFF : (k == 1) ? 8'h00 : rand_byte();
      implied_op(k[0] ? `OP_SEC_IMP : `OP_CLC_IMP);
      operand_op(`OP_INC_ABS, v);
      operand_op(`OP_DEC_ABS, v);
      operand_op(`OP_LDA_ABS, 8'h00);
      operand_op(`OP_ADC_ABS, 8'h00);
      fresh_store(`OP_STA_ABS);
    end
    cur_test = 5;
    implied_op(`OP_NOP_IMP);
    implied_op(`OP_NOP_IMP);
    fresh_store(`OP_STA_ABS);
    fresh_store(`OP_STX_ABS);
    fresh_store(`OP_STY_ABS);
    jump_to(16'h0800 | {8'h00, rand_byte()});
    implied_op(`OP_NOP_IMP);
    cur_test = 6;
    illegal_op(8'h02);
  endtask

  // ----------------------------------------
  // Waiting and per-instruction checks
  task automatic wait_sync(input string what);
    int n;
    if (timed_out) begin
      return;
    end
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!sync && n < SYNC_LIMIT);
    if (!sync) begin
      timed_out = 1'b1;
      $display("timeout: no opcode fetch within %0d cycles while waiting for %s",
               SYNC_LIMIT, what);
    end
    sync_cycle = cycle;
  endtask

  task automatic check_step(input int i);
    int start;
    start = sync_cycle;
    wait_sync($sformatf("the fetch after the instruction at %h", exp_pc[i]));
    if (timed_out) begin
      return;
    end
    check(sync_cycle - start == exp_len[i],
          $sformatf("instruction at %h took %0d cycles, expected %0d",
                    exp_pc[i], sync_cycle - start, exp_len[i]));
    check(address == exp_pc[i+1],
          $sformatf("fetch address %h, expected %h", address, exp_pc[i+1]));
    check(wr_addr_q.size() == exp_wr_cnt[i],
          $sformatf("%0d writes by instruction at %h, expected %0d",
                    wr_addr_q.size(), exp_pc[i], exp_wr_cnt[i]));
    if (exp_wr_cnt[i] == 1 && wr_addr_q.size() == 1) begin
      check(wr_addr_q[0] == exp_wr_addr[i],
            $sformatf("write address %h, expected %h", wr_addr_q[0], exp_wr_addr[i]));
      check(wr_data_q[0] == exp_wr_data[i],
            $sformatf("write data %h at %h, expected %h",
                      wr_data_q[0], wr_addr_q[0], exp_wr_data[i]));
    end
    wr_addr_q.delete();
    wr_data_q.delete();
  endtask

  task automatic check_halt();
    int n;
    if (timed_out) begin
      return;
    end
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!halted && n < SYNC_LIMIT);
    if (!halted) begin
      timed_out = 1'b1;
      $display("timeout: halted never went high after the illegal opcode");
      return;
    end
    check(n == 1, $sformatf("halted rose %0d cycles after the fetch, expected 1", n));
    // Quiet bus for the whole window
    repeat (HALT_WINDOW) begin
      @(negedge clk);
      check(!sync, "opcode fetch while halted");
      check(halted, "halted dropped before reset");
    end
    check(wr_addr_q.size() == 0,
          $sformatf("%0d writes after the halt, expected 0", wr_addr_q.size()));
  endtask

  task automatic end_test(input int t);
    logic ok;
    ok = (errors == test_err_base) && !timed_out;
    if (ok) begin
      tests_ok++;
    end else begin
      tests_bad++;
    end
    $display("test %0d %s: %s", t, test_title(t), ok ? "ok" : "failed");
    test_err_base = errors;
  endtask

  // ----------------------------------------
  // Main sequence
  initial begin
    int i;
    resetn = 1'b0;
    // Memory pattern is in place after the first edge
    @(posedge clk);
    build_program();
    repeat (3) begin
      @(negedge clk);
      check(!sync && !wr_enable && !halted, "strobe active while in reset");
    end
    repeat (2) @(posedge clk);
    resetn <= 1'b1;
    @(negedge clk);
    release_cycle = cycle;

    wait_sync("the first opcode fetch");
    if (!timed_out) begin
      check(address == exp_pc[0],
            $sformatf("first fetch at %h, expected reset vector %h", address, exp_pc[0]));
      check(sync_cycle == release_cycle + 2,
            $sformatf("first fetch %0d cycles after reset, expected 2",
                      sync_cycle - release_cycle));
      check(wr_addr_q.size() == 0, "write before the first opcode fetch");
    end
    wr_addr_q.delete();
    wr_data_q.delete();
    end_test(1);

    for (i = 0; i < exp_len.size(); i++) begin
      if (exp_len[i] == 0) begin
        check_halt();
      end else begin
        check_step(i);
      end
      if (i == exp_len.size() - 1 || exp_test[i+1] != exp_test[i]) begin
        end_test(exp_test[i]);
      end
    end

    $display("summary: %0d tests ok, %0d tests failed, %0d check errors%s",
             tests_ok, tests_bad, errors, timed_out ? ", run timed out" : "");
    if (errors == 0 && tests_bad == 0 && !timed_out) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- bench/tb_memory.sv
/*
  Behavioural 64K-byte memory for the core testbench
  Combinational read, write on the rising clock edge and byte loading
  for programs and data. Bytes never loaded hold an address pattern
*/
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_memory (
  input  logic                   clk,
  input  logic [`CPU_ADDR_W-1:0] address,
  input  logic [`CPU_DATA_W-1:0] wr_data,
  input  logic                   wr_enable,
  output logic [`CPU_DATA_W-1:0] rd_data
);

  logic [`CPU_DATA_W-1:0] mem_array [0:(1 << `CPU_ADDR_W)-1];

  // Pattern mixes both address bytes
  initial begin
    for (int i = 0; i < (1 << `CPU_ADDR_W); i++) begin
      mem_array[i[15:0]] = i[15:8] ^ {i[6:0], i[7]} ^ 8'h96;
    end
  end

  assign rd_data = mem_array[address];

  always @(posedge clk) begin
    if (wr_enable) begin
      mem_array[address] <= wr_data;
    end
  end

  // Program and data loading from the testbench
  task automatic load_byte(input logic [15:0] a, input logic [7:0] d);
    mem_array[a] = d;
  endtask

endmodule

//--- src/cpu_top.sv
/*
  Reduced 6502 core, top level
  Sequencer, opcode decoder, ALU and register file on one memory bus
  with combinational read and clocked write
*/
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_top (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic [`CPU_DATA_W-1:0] rd_data,
  output logic [`CPU_ADDR_W-1:0] address,
  output logic [`CPU_DATA_W-1:0] wr_data,
  output logic                   wr_enable,
  output logic                   sync,
  output logic                   halted
);

  // Decode results
  cpu_isa_pkg::opcode_u   ir;
  logic [`CPU_CLS_W-1:0]  ins_class;
  logic [`CPU_ALU_W-1:0]  alu_op;
  logic [`CPU_SEL_W-1:0]  src_sel;
  logic [`CPU_SEL_W-1:0]  dst_sel;
  logic [`CPU_CY_W-1:0]   carry_op;

  // Datapath
  logic [`CPU_DATA_W-1:0] mem_data;
  logic [`CPU_DATA_W-1:0] src_value;
  logic [`CPU_DATA_W-1:0] result;
  logic                   carry;
  logic                   carry_out;
  logic                   commit;

  cpu_sequencer u_sequencer (
    .clk        (clk),
    .resetn     (resetn),
    .rd_data    (rd_data),
    .ins_class  (ins_class),
    .alu_result (result),
    .ir         (ir),
    .address    (address),
    .mem_data   (mem_data),
    .wr_data    (wr_data),
    .wr_enable  (wr_enable),
    .commit     (commit),
    .sync       (sync),
    .halted     (halted)
  );

  opcode_decoder u_decoder (
    .ir        (ir),
    .ins_class (ins_class),
    .alu_op    (alu_op),
    .src_sel   (src_sel),
    .dst_sel   (dst_sel),
    .carry_op  (carry_op)
  );

  alu u_alu (
    .alu_op    (alu_op),
    .src_value (src_value),
    .mem_data  (mem_data),
    .carry     (carry),
    .result    (result),
    .carry_out (carry_out)
  );

  reg_file u_reg_file (
    .clk       (clk),
    .resetn    (resetn),
    .commit    (commit),
    .src_sel   (src_sel),
    .dst_sel   (dst_sel),
    .carry_op  (carry_op),
    .result    (result),
    .carry_out (carry_out),
    .src_value (src_value),
    .carry     (carry)
  );

endmodule

//--- sequencer/cpu_sequencer.sv
/*
  Instruction sequencer
  One instruction at a time through a multi-cycle FSM: reset vector,
  opcode fetch, absolute operand bytes, memory access and RMW write-back.
  Owns the PC, the instruction register and the bus address and write strobe
*/
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_sequencer (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic [`CPU_DATA_W-1:0] rd_data,
  input  logic [`CPU_CLS_W-1:0]  ins_class,
  input  logic [`CPU_DATA_W-1:0] alu_result,
  output cpu_isa_pkg::opcode_u   ir,
  output logic [`CPU_ADDR_W-1:0] address,
  output logic [`CPU_DATA_W-1:0] mem_data,
  output logic [`CPU_DATA_W-1:0] wr_data,
  output logic                   wr_enable,
  output logic                   commit,
  output logic                   sync,
  output logic                   halted
);

  logic [`CPU_STATE_W-1:0] state;
  logic [`CPU_STATE_W-1:0] state_next;
  logic [`CPU_ADDR_W-1:0]  pc;
  cpu_isa_pkg::opcode_u    ir_q;
  logic [`CPU_DATA_W-1:0]  oper_lo;
  logic [`CPU_DATA_W-1:0]  oper_hi;
  logic [`CPU_DATA_W-1:0]  mem_byte;
  logic [`CPU_ADDR_W-1:0]  operand;

  assign operand = {oper_hi, oper_lo};

  // ----------------------------------------
  // State register
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= `ST_VEC_LO;
    end else begin
      state <= state_next;
    end
  end

  // Next state, class only matters at branch points
  always_comb begin
    state_next = state;
    case (state)
      `ST_VEC_LO:  state_next = `ST_VEC_HI;
      `ST_VEC_HI:  state_next = `ST_FETCH;
      `ST_FETCH: begin
        if (ins_class == `CLS_ILLEGAL) begin
          state_next = `ST_HALT;
        end else if (ins_class == `CLS_IMPLIED) begin
          state_next = `ST_IMPLIED;
        end else begin
          state_next = `ST_OPER_LO;
        end
      end
      `ST_IMPLIED: state_next = `ST_FETCH;
      `ST_OPER_LO: state_next = `ST_OPER_HI;
      // JMP is done once the high byte is in
      `ST_OPER_HI: state_next = (ins_class == `CLS_JUMP) ? `ST_FETCH : `ST_MEM;
      `ST_MEM:     state_next = (ins_class == `CLS_RMW) ? `ST_MODIFY : `ST_FETCH;
      `ST_MODIFY:  state_next = `ST_WRITE;
      `ST_WRITE:   state_next = `ST_FETCH;
      // Halt state and unused codes stay halted
      default:     state_next = `ST_HALT;
    endcase
  end

  // ----------------------------------------
  // PC, instruction and operand registers
  always_ff @(posedge clk) begin
    case (state)
      `ST_VEC_LO:  pc[7:0]  <= rd_data;
      `ST_VEC_HI:  pc[15:8] <= rd_data;
      `ST_FETCH:   ir_q.raw <= rd_data;
      `ST_IMPLIED: pc       <= pc + 16'd1;
      `ST_OPER_LO: oper_lo  <= rd_data;
      `ST_OPER_HI: begin
        oper_hi <= rd_data;
        // Jump target straight from the bus
        if (ins_class == `CLS_JUMP) begin
          pc <= {rd_data, oper_lo};
        end
      end
      `ST_MEM: begin
        // Byte kept for the modify and write cycles
        mem_byte <= rd_data;
        if (ins_class != `CLS_RMW) begin
          pc <= pc + 16'd3;
        end
      end
      `ST_WRITE:   pc <= pc + 16'd3;
      default: begin
      end
    endcase
  end

  // Decoder sees the opcode on the bus during fetch
  always_comb begin
    if (state == `ST_FETCH) begin
      ir.raw = rd_data;
    end else begin
      ir = ir_q;
    end
  end

  // ----------------------------------------
  // Bus address and strobes
  always_comb begin
    address   = pc;
    sync      = 1'b0;
    commit    = 1'b0;
    wr_enable = 1'b0;
    halted    = 1'b0;
    case (state)
      `ST_VEC_LO:  address = `CPU_RESET_VEC_LO;
      `ST_VEC_HI:  address = `CPU_RESET_VEC_HI;
      `ST_FETCH:   sync = 1'b1;
      `ST_IMPLIED: begin
        address = pc + 16'd1;
        commit  = 1'b1;
      end
      `ST_OPER_LO: address = pc + 16'd1;
      `ST_OPER_HI: address = pc + 16'd2;
      `ST_MEM: begin
        address   = operand;
        commit    = (ins_class == `CLS_READ);
        wr_enable = (ins_class == `CLS_STORE);
      end
      `ST_MODIFY:  address = operand;
      `ST_WRITE: begin
        address   = operand;
        wr_enable = 1'b1;
      end
      `ST_HALT:    halted = 1'b1;
      default: begin
      end
    endcase
  end

  // Live read data except while the latched RMW byte is in use
  assign mem_data = (state == `ST_MODIFY || state == `ST_WRITE) ? mem_byte : rd_data;

  // Stores and RMW write back whatever the ALU produces
  assign wr_data = alu_result;

endmodule

//--- sequencer/opcode_decoder.sv
/*
  Opcode decoder
  Group-one absolute instructions decode from the aaa/bbb/cc fields,
  the rest by raw value. Anything unknown is illegal
*/
`timescale 1ns/1ps
`include "cpu_defs.svh"

module opcode_decoder (
  input  cpu_isa_pkg::opcode_u   ir,
  output logic [`CPU_CLS_W-1:0]  ins_class,
  output logic [`CPU_ALU_W-1:0]  alu_op,
  output logic [`CPU_SEL_W-1:0]  src_sel,
  output logic [`CPU_SEL_W-1:0]  dst_sel,
  output logic [`CPU_CY_W-1:0]   carry_op
);

  always_comb begin
    // Defaults: illegal, no register or carry change
    ins_class = `CLS_ILLEGAL;
    alu_op    = `ALU_LOAD;
    src_sel   = `REG_A;
    dst_sel   = `REG_NONE;
    carry_op  = `CY_KEEP;

    if (ir.f.cc == `CPU_GRP1_CC && ir.f.bbb == `CPU_MODE_ABS) begin
      // ----------------------------------------
      // Group one, accumulator against memory
      ins_class = `CLS_READ;
      dst_sel   = `REG_A;
      case (ir.f.aaa)
        `GRP1_ORA: alu_op = `ALU_ORA;
        `GRP1_AND: alu_op = `ALU_AND;
        `GRP1_EOR: alu_op = `ALU_EOR;
        `GRP1_ADC: begin
          alu_op   = `ALU_ADC;
          carry_op = `CY_ALU;
        end
        `GRP1_LDA: alu_op = `ALU_LOAD;
        `GRP1_STA: begin
          ins_class = `CLS_STORE;
          alu_op    = `ALU_STORE;
          dst_sel   = `REG_NONE;
        end
        // Only the borrow survives, A untouched
        `GRP1_CMP: begin
          alu_op   = `ALU_CMP;
          dst_sel  = `REG_NONE;
          carry_op = `CY_ALU;
        end
        // SBC not supported
        default: begin
          ins_class = `CLS_ILLEGAL;
          dst_sel   = `REG_NONE;
        end
      endcase
    end else begin
      // ----------------------------------------
      // Everything else by exact value
      case (ir.raw)
        `OP_LDX_ABS: begin
          ins_class = `CLS_READ;
          dst_sel   = `REG_X;
        end
        `OP_LDY_ABS: begin
          ins_class = `CLS_READ;
          dst_sel   = `REG_Y;
        end
        `OP_STX_ABS: begin
          ins_class = `CLS_STORE;
          alu_op    = `ALU_STORE;
          src_sel   = `REG_X;
        end
        `OP_STY_ABS: begin
          ins_class = `CLS_STORE;
          alu_op    = `ALU_STORE;
          src_sel   = `REG_Y;
        end
        `OP_INC_ABS: begin
          ins_class = `CLS_RMW;
          alu_op    = `ALU_INC;
        end
        `OP_DEC_ABS: begin
          ins_class = `CLS_RMW;
          alu_op    = `ALU_DEC;
        end
        `OP_JMP_ABS: ins_class = `CLS_JUMP;
        `OP_CLC_IMP: begin
          ins_class = `CLS_IMPLIED;
          carry_op  = `CY_CLEAR;
        end
        `OP_SEC_IMP: begin
          ins_class = `CLS_IMPLIED;
          carry_op  = `CY_SET;
        end
        `OP_NOP_IMP: ins_class = `CLS_IMPLIED;
        default: begin
        end
      endcase
    end
  end

endmodule

//--- execute/reg_file.sv
/*
  Register file
  A, X, Y and the carry flag. Source read is combinational,
  destination and carry update on the commit strobe
*/
`timescale 1ns/1ps
`include "cpu_defs.svh"

module reg_file (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   commit,
  input  logic [`CPU_SEL_W-1:0]  src_sel,
  input  logic [`CPU_SEL_W-1:0]  dst_sel,
  input  logic [`CPU_CY_W-1:0]   carry_op,
  input  logic [`CPU_DATA_W-1:0] result,
  input  logic                   carry_out,
  output logic [`CPU_DATA_W-1:0] src_value,
  output logic                   carry
);

  logic [`CPU_DATA_W-1:0] reg_a;
  logic [`CPU_DATA_W-1:0] reg_x;
  logic [`CPU_DATA_W-1:0] reg_y;

  // Source read-out, REG_NONE reads zero
  always_comb begin
    case (src_sel)
      `REG_A:  src_value = reg_a;
      `REG_X:  src_value = reg_x;
      `REG_Y:  src_value = reg_y;
      default: src_value = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      reg_a <= '0;
      reg_x <= '0;
      reg_y <= '0;
      carry <= 1'b0;
    end else if (commit) begin
      // Destination write
      case (dst_sel)
        `REG_A:  reg_a <= result;
        `REG_X:  reg_x <= result;
        `REG_Y:  reg_y <= result;
        default: begin
        end
      endcase
      // Carry action
      case (carry_op)
        `CY_CLEAR: carry <= 1'b0;
        `CY_SET:   carry <= 1'b1;
        `CY_ALU:   carry <= carry_out;
        default:   carry <= carry;
      endcase
    end
  end

endmodule

//--- execute/alu.sv
/*
  8-bit ALU
  Pass-through for loads and stores, logic ops and ADC on A and M,
  compare borrow, and memory increment/decrement for RMW
*/
`timescale 1ns/1ps
`include "cpu_defs.svh"

module alu (
  input  logic [`CPU_ALU_W-1:0]  alu_op,
  input  logic [`CPU_DATA_W-1:0] src_value,
  input  logic [`CPU_DATA_W-1:0] mem_data,
  input  logic                   carry,
  output logic [`CPU_DATA_W-1:0] result,
  output logic                   carry_out
);

  // Extra bit catches carry or borrow
  logic [`CPU_DATA_W:0] sum;
  logic [`CPU_DATA_W:0] diff;

  assign sum  = {1'b0, src_value} + {1'b0, mem_data} + {{`CPU_DATA_W{1'b0}}, carry};
  assign diff = {1'b0, src_value} - {1'b0, mem_data};

  always_comb begin
    // Carry passes through unless the op says otherwise
    result    = mem_data;
    carry_out = carry;
    case (alu_op)
      `ALU_LOAD:  result = mem_data;
      `ALU_STORE: result = src_value;
      `ALU_ORA:   result = src_value | mem_data;
      `ALU_AND:   result = src_value & mem_data;
      `ALU_EOR:   result = src_value ^ mem_data;
      `ALU_ADC: begin
        result    = sum[`CPU_DATA_W-1:0];
        carry_out = sum[`CPU_DATA_W];
      end
      // C set when A >= M, i.e. no borrow
      `ALU_CMP: begin
        result    = diff[`CPU_DATA_W-1:0];
        carry_out = ~diff[`CPU_DATA_W];
      end
      `ALU_INC:   result = mem_data + 8'd1;
      `ALU_DEC:   result = mem_data - 8'd1;
      default: begin
      end
    endcase
  end

endmodule

//--- common/cpu_isa_pkg.sv
/*
  Instruction set types of the reduced 6502 core
  One opcode byte, seen either raw or as its aaa/bbb/cc fields
*/
`include "cpu_defs.svh"

package cpu_isa_pkg;

  // Field view of an opcode byte
  typedef struct packed {
    logic [2:0] aaa;
    logic [2:0] bbb;
    logic [1:0] cc;
  } opcode_fields_t;

  // Same byte, raw or split into fields
  typedef union packed {
    logic [`CPU_DATA_W-1:0] raw;
    opcode_fields_t         f;
  } opcode_u;

endpackage

//--- common/cpu_defs.svh
/*
  Shared constants for the reduced 6502 core
  Bus widths, reset vector, opcode values, group-one field values,
  sequencer states, instruction classes, ALU operations,
  register selects and carry actions
*/
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// ----------------------------------------
// Widths
`define CPU_ADDR_W        16
`define CPU_DATA_W        8
`define CPU_STATE_W       4
`define CPU_CLS_W         3
`define CPU_ALU_W         4
`define CPU_SEL_W         2
`define CPU_CY_W          2

// Reset vector bytes
`define CPU_RESET_VEC_LO  16'hFFFC
`define CPU_RESET_VEC_HI  16'hFFFD

// ----------------------------------------
// Opcodes of the kept instructions
`define OP_LDA_ABS        8'hAD
`define OP_LDX_ABS        8'hAE
`define OP_LDY_ABS        8'hAC
`define OP_STA_ABS        8'h8D
`define OP_STX_ABS        8'h8E
`define OP_STY_ABS        8'h8C
`define OP_ORA_ABS        8'h0D
`define OP_AND_ABS        8'h2D
`define OP_EOR_ABS        8'h4D
`define OP_ADC_ABS        8'h6D
`define OP_CMP_ABS        8'hCD
`define OP_INC_ABS        8'hEE
`define OP_DEC_ABS        8'hCE
`define OP_JMP_ABS        8'h4C
`define OP_CLC_IMP        8'h18
`define OP_SEC_IMP        8'h38
`define OP_NOP_IMP        8'hEA

// Group-one field values (cc, bbb) and aaa operations
`define CPU_GRP1_CC       2'b01
`define CPU_MODE_ABS      3'b011
`define GRP1_ORA          3'b000
`define GRP1_AND          3'b001
`define GRP1_EOR          3'b010
`define GRP1_ADC          3'b011
`define GRP1_STA          3'b100
`define GRP1_LDA          3'b101
`define GRP1_CMP          3'b110

// ----------------------------------------
// Sequencer states
`define ST_VEC_LO         4'd0
`define ST_VEC_HI         4'd1
`define ST_FETCH          4'd2
`define ST_IMPLIED        4'd3
`define ST_OPER_LO        4'd4
`define ST_OPER_HI        4'd5
`define ST_MEM            4'd6
`define ST_MODIFY         4'd7
`define ST_WRITE          4'd8
`define ST_HALT           4'd9

// Instruction classes
`define CLS_IMPLIED       3'd0
`define CLS_JUMP          3'd1
`define CLS_READ          3'd2
`define CLS_STORE         3'd3
`define CLS_RMW           3'd4
`define CLS_ILLEGAL       3'd5

// ALU operations
`define ALU_LOAD          4'd0
`define ALU_STORE         4'd1
`define ALU_ORA           4'd2
`define ALU_AND           4'd3
`define ALU_EOR           4'd4
`define ALU_ADC           4'd5
`define ALU_CMP           4'd6
`define ALU_INC           4'd7
`define ALU_DEC           4'd8

// Register selects
`define REG_A             2'd0
`define REG_X             2'd1
`define REG_Y             2'd2
`define REG_NONE          2'd3

// Carry actions
`define CY_KEEP           2'd0
`define CY_CLEAR          2'd1
`define CY_SET            2'd2
`define CY_ALU            2'd3

`endif
